// File: logic/tcm_defs.svh
/*
 TCM subsystem widths and memory map.
 Shared by the package, the bus interface, the router and the top level.
 */

`ifndef TCM_DEFS_SVH
`define TCM_DEFS_SVH

`define TCM_ADDR_W 32
`define TCM_DATA_W 32
`define TCM_ID_W   2
`define TCM_CNT_W  4

// bank windows, sizes in bytes
`define ITCM_BASE 32'h0000_0000
`define ITCM_SIZE 32'h0000_1000
`define DTCM_BASE 32'h1000_0000
`define DTCM_SIZE 32'h0000_1000

`endif

// File: logic/tcm_pkg.sv
/*
 TCM subsystem types.
 Address, data, id, strobe and counter types plus the bank FSM states.
 */

`default_nettype none

`include "tcm_defs.svh"

package tcm_pkg;

    typedef logic [`TCM_ADDR_W-1:0]   tcm_addr_t;
    typedef logic [`TCM_DATA_W-1:0]   tcm_data_t;
    typedef logic [`TCM_ID_W-1:0]     tcm_id_t;
    typedef logic [`TCM_DATA_W/8-1:0] tcm_strb_t;
    typedef logic [`TCM_CNT_W-1:0]    tcm_cnt_t;

    // one transaction at a time per bank
    typedef enum logic [1:0] {bank_idle, bank_rd_resp, bank_wr_resp} bank_state_e;

endpackage

`default_nettype wire

// File: logic/tcm_bus_if.sv
/*
 TCM bank bus.
 Read address, read data, combined write address/data and write response
 channels between the router and one memory bank.
 */

`timescale 1ns/1ps
`default_nettype none

`include "tcm_defs.svh"

interface tcm_bus_if;

    logic                ar_valid;
    logic                ar_ready;
    tcm_pkg::tcm_addr_t  ar_addr;
    tcm_pkg::tcm_id_t    ar_id;
    logic                r_valid;
    logic                r_ready;
    tcm_pkg::tcm_data_t  r_data;
    tcm_pkg::tcm_id_t    r_id;
    // write carries address and data in one beat
    logic                aw_valid;
    logic                aw_ready;
    tcm_pkg::tcm_addr_t  aw_addr;
    tcm_pkg::tcm_id_t    aw_id;
    tcm_pkg::tcm_data_t  w_data;
    tcm_pkg::tcm_strb_t  w_strb;
    logic                b_valid;
    logic                b_ready;
    tcm_pkg::tcm_id_t    b_id;

    modport router (
        output ar_valid, ar_addr, ar_id, r_ready,
        output aw_valid, aw_addr, aw_id, w_data, w_strb, b_ready,
        input  ar_ready, r_valid, r_data, r_id, aw_ready, b_valid, b_id
    );

    modport bank (
        input  ar_valid, ar_addr, ar_id, r_ready,
        input  aw_valid, aw_addr, aw_id, w_data, w_strb, b_ready,
        output ar_ready, r_valid, r_data, r_id, aw_ready, b_valid, b_id
    );

endinterface

`default_nettype wire

// File: logic/tcm_outstanding_cnt.sv
/*
 Outstanding transaction counter.
 Counts requests accepted on one master/bank/direction path whose
 response has not yet been taken.
 */

`timescale 1ns/1ps
`default_nettype none

module tcm_outstanding_cnt (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               inc,
    input  wire               dec,
    output logic              busy,
    output tcm_pkg::tcm_cnt_t count
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (inc && !dec) begin
            count <= count + 1'b1;
        end else if (dec && !inc) begin
            count <= count - 1'b1;
        end
        // inc and dec together leave the count as it is
    end

    assign busy = (count != '0);

endmodule

`default_nettype wire

// File: logic/tcm_bank.sv
/*
 TCM bank controller.
 Accepts one read or write at a time, holds the response until it is
 taken, and stores words in a byte-writable array.
 */

`timescale 1ns/1ps
`default_nettype none

module tcm_bank #(
    parameter int DEPTH_WORDS = 1024
) (
    input wire       clk,
    input wire       rst_n,
    tcm_bus_if.bank  bus
);

    localparam int OFF_W = $clog2($bits(tcm_pkg::tcm_strb_t));
    localparam int IDX_W = $clog2(DEPTH_WORDS);

    tcm_pkg::bank_state_e state;

    tcm_pkg::tcm_data_t mem [DEPTH_WORDS];
    tcm_pkg::tcm_data_t rd_data;
    tcm_pkg::tcm_id_t   rd_id;
    tcm_pkg::tcm_id_t   wr_id;

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic             rd_fire;
    logic             wr_fire;

    // word index sits just above the byte offset
    assign rd_idx = bus.ar_addr[OFF_W +: IDX_W];
    assign wr_idx = bus.aw_addr[OFF_W +: IDX_W];

    // read wins when both are offered in idle
    assign bus.ar_ready = (state == tcm_pkg::bank_idle);
    assign bus.aw_ready = (state == tcm_pkg::bank_idle) && !bus.ar_valid;

    assign rd_fire = bus.ar_valid && bus.ar_ready;
    assign wr_fire = bus.aw_valid && bus.aw_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= tcm_pkg::bank_idle;
        end else begin
            case (state)
                tcm_pkg::bank_idle: begin
                    if (rd_fire) begin
                        state <= tcm_pkg::bank_rd_resp;
                    end else if (wr_fire) begin
                        state <= tcm_pkg::bank_wr_resp;
                    end
                end
                tcm_pkg::bank_rd_resp: begin
                    if (bus.r_ready) begin
                        state <= tcm_pkg::bank_idle;
                    end
                end
                tcm_pkg::bank_wr_resp: begin
                    if (bus.b_ready) begin
                        state <= tcm_pkg::bank_idle;
                    end
                end
                default: state <= tcm_pkg::bank_idle;
            endcase
        end
    end

    // response payload, held until the handshake
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rd_data <= mem[rd_idx];
            rd_id   <= bus.ar_id;
        end
        if (wr_fire) begin
            wr_id <= bus.aw_id;
        end
    end

    // byte lanes merge into the stored word
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int i = 0; i < $bits(tcm_pkg::tcm_strb_t); i++) begin
                if (bus.w_strb[i]) begin
                    mem[wr_idx][8*i +: 8] <= bus.w_data[8*i +: 8];
                end
            end
        end
    end

    assign bus.r_valid = (state == tcm_pkg::bank_rd_resp);
    assign bus.r_data  = rd_data;
    assign bus.r_id    = rd_id;
    assign bus.b_valid = (state == tcm_pkg::bank_wr_resp);
    assign bus.b_id    = wr_id;

endmodule

`default_nettype wire

// File: logic/tcm_router.sv
/*
 TCM request router.
 Decodes master addresses onto the ITCM and DTCM windows, arbitrates
 the ITCM read channel with m1 first, and steers responses back using
 per-path outstanding counters.
 */

`timescale 1ns/1ps
`default_nettype none

`include "tcm_defs.svh"

module tcm_router (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     m0_ar_valid,
    output logic                    m0_ar_ready,
    input  wire tcm_pkg::tcm_addr_t m0_ar_addr,
    input  wire tcm_pkg::tcm_id_t   m0_ar_id,
    output logic                    m0_r_valid,
    input  wire                     m0_r_ready,
    output tcm_pkg::tcm_data_t      m0_r_data,
    output tcm_pkg::tcm_id_t        m0_r_id,
    input  wire                     m1_ar_valid,
    output logic                    m1_ar_ready,
    input  wire tcm_pkg::tcm_addr_t m1_ar_addr,
    input  wire tcm_pkg::tcm_id_t   m1_ar_id,
    output logic                    m1_r_valid,
    input  wire                     m1_r_ready,
    output tcm_pkg::tcm_data_t      m1_r_data,
    output tcm_pkg::tcm_id_t        m1_r_id,
    input  wire                     m1_aw_valid,
    output logic                    m1_aw_ready,
    input  wire tcm_pkg::tcm_addr_t m1_aw_addr,
    input  wire tcm_pkg::tcm_id_t   m1_aw_id,
    input  wire tcm_pkg::tcm_data_t m1_w_data,
    input  wire tcm_pkg::tcm_strb_t m1_w_strb,
    output logic                    m1_b_valid,
    input  wire                     m1_b_ready,
    output tcm_pkg::tcm_id_t        m1_b_id,
    tcm_bus_if.router               itcm,
    tcm_bus_if.router               dtcm
);

    logic m0_ar_itcm, m1_ar_itcm, m1_ar_dtcm, m1_aw_itcm, m1_aw_dtcm;
    logic m0_grant, m1_itcm_rd_req;
    logic m0_itcm_rd_busy, m1_itcm_rd_busy, m1_dtcm_rd_busy;
    logic m1_itcm_wr_busy, m1_dtcm_wr_busy;

    // wraps below base, so one compare covers both bounds
    function automatic logic in_window(tcm_pkg::tcm_addr_t addr, tcm_pkg::tcm_addr_t base,
                                       tcm_pkg::tcm_addr_t size);
        return (addr - base) < size;
    endfunction

    assign m0_ar_itcm = in_window(m0_ar_addr, `ITCM_BASE, `ITCM_SIZE);
    assign m1_ar_itcm = in_window(m1_ar_addr, `ITCM_BASE, `ITCM_SIZE);
    assign m1_ar_dtcm = in_window(m1_ar_addr, `DTCM_BASE, `DTCM_SIZE);
    assign m1_aw_itcm = in_window(m1_aw_addr, `ITCM_BASE, `ITCM_SIZE);
    assign m1_aw_dtcm = in_window(m1_aw_addr, `DTCM_BASE, `DTCM_SIZE);

    // m0 only gets the ITCM read channel when m1 is not asking for it
    assign m1_itcm_rd_req = m1_ar_valid && m1_ar_itcm;
    assign m0_grant       = !m1_itcm_rd_req;

    assign itcm.ar_valid = m1_itcm_rd_req || (m0_ar_valid && m0_ar_itcm);
    assign itcm.ar_addr  = m1_itcm_rd_req ? m1_ar_addr : m0_ar_addr;
    assign itcm.ar_id    = m1_itcm_rd_req ? m1_ar_id : m0_ar_id;
    assign dtcm.ar_valid = m1_ar_valid && m1_ar_dtcm;
    assign dtcm.ar_addr  = m1_ar_addr;
    assign dtcm.ar_id    = m1_ar_id;

    // unmapped addresses never see ready
    assign m0_ar_ready = m0_ar_itcm && m0_grant && itcm.ar_ready;
    assign m1_ar_ready = (m1_ar_itcm && itcm.ar_ready) || (m1_ar_dtcm && dtcm.ar_ready);

    assign itcm.aw_valid = m1_aw_valid && m1_aw_itcm;
    assign dtcm.aw_valid = m1_aw_valid && m1_aw_dtcm;
    assign itcm.aw_addr  = m1_aw_addr;
    assign dtcm.aw_addr  = m1_aw_addr;
    assign itcm.aw_id    = m1_aw_id;
    assign dtcm.aw_id    = m1_aw_id;
    assign itcm.w_data   = m1_w_data;
    assign dtcm.w_data   = m1_w_data;
    assign itcm.w_strb   = m1_w_strb;
    assign dtcm.w_strb   = m1_w_strb;
    assign m1_aw_ready   = (m1_aw_itcm && itcm.aw_ready) || (m1_aw_dtcm && dtcm.aw_ready);

    // read responses
    assign m0_r_valid = itcm.r_valid && m0_itcm_rd_busy;
    assign m0_r_data  = itcm.r_data;
    assign m0_r_id    = itcm.r_id;
    assign m1_r_valid = m1_itcm_rd_busy ? itcm.r_valid : (dtcm.r_valid && m1_dtcm_rd_busy);
    assign m1_r_data  = m1_itcm_rd_busy ? itcm.r_data : dtcm.r_data;
    assign m1_r_id    = m1_itcm_rd_busy ? itcm.r_id : dtcm.r_id;

    assign itcm.r_ready = (m0_r_ready && m0_itcm_rd_busy) || (m1_r_ready && m1_itcm_rd_busy);
    assign dtcm.r_ready = m1_r_ready && m1_dtcm_rd_busy && !m1_itcm_rd_busy;

    // write responses, chosen the same way
    assign m1_b_valid   = m1_itcm_wr_busy ? itcm.b_valid : (dtcm.b_valid && m1_dtcm_wr_busy);
    assign m1_b_id      = m1_itcm_wr_busy ? itcm.b_id : dtcm.b_id;
    assign itcm.b_ready = m1_b_ready && m1_itcm_wr_busy;
    assign dtcm.b_ready = m1_b_ready && m1_dtcm_wr_busy && !m1_itcm_wr_busy;

    tcm_outstanding_cnt m0_itcm_rd_cnt (
        .clk(clk), .rst_n(rst_n), .inc(m0_ar_valid && m0_ar_ready),
        .dec(m0_r_valid && m0_r_ready), .busy(m0_itcm_rd_busy), .count()
    );
    tcm_outstanding_cnt m1_itcm_rd_cnt (
        .clk(clk), .rst_n(rst_n), .inc(m1_itcm_rd_req && itcm.ar_ready),
        .dec(itcm.r_valid && m1_r_ready && m1_itcm_rd_busy), .busy(m1_itcm_rd_busy), .count()
    );
    tcm_outstanding_cnt m1_dtcm_rd_cnt (
        .clk(clk), .rst_n(rst_n), .inc(dtcm.ar_valid && dtcm.ar_ready),
        .dec(dtcm.r_valid && dtcm.r_ready), .busy(m1_dtcm_rd_busy), .count()
    );
    tcm_outstanding_cnt m1_itcm_wr_cnt (
        .clk(clk), .rst_n(rst_n), .inc(itcm.aw_valid && itcm.aw_ready),
        .dec(itcm.b_valid && itcm.b_ready), .busy(m1_itcm_wr_busy), .count()
    );
    tcm_outstanding_cnt m1_dtcm_wr_cnt (
        .clk(clk), .rst_n(rst_n), .inc(dtcm.aw_valid && dtcm.aw_ready),
        .dec(dtcm.b_valid && dtcm.b_ready), .busy(m1_dtcm_wr_busy), .count()
    );

endmodule

`default_nettype wire

// File: logic/tcm_subsys.sv
/*
 TCM subsystem top level.
 Fetch port m0 and load/store port m1 reach an ITCM and a DTCM bank
 through the request router.
 */

`timescale 1ns/1ps
`default_nettype none

`include "tcm_defs.svh"

module tcm_subsys (
    input  wire                     clk,
    input  wire                     rst_n,
    // m0 fetch, read only
    input  wire                     m0_ar_valid,
    output logic                    m0_ar_ready,
    input  wire tcm_pkg::tcm_addr_t m0_ar_addr,
    input  wire tcm_pkg::tcm_id_t   m0_ar_id,
    output logic                    m0_r_valid,
    input  wire                     m0_r_ready,
    output tcm_pkg::tcm_data_t      m0_r_data,
    output tcm_pkg::tcm_id_t        m0_r_id,
    // m1 load/store
    input  wire                     m1_ar_valid,
    output logic                    m1_ar_ready,
    input  wire tcm_pkg::tcm_addr_t m1_ar_addr,
    input  wire tcm_pkg::tcm_id_t   m1_ar_id,
    output logic                    m1_r_valid,
    input  wire                     m1_r_ready,
    output tcm_pkg::tcm_data_t      m1_r_data,
    output tcm_pkg::tcm_id_t        m1_r_id,
    input  wire                     m1_aw_valid,
    output logic                    m1_aw_ready,
    input  wire tcm_pkg::tcm_addr_t m1_aw_addr,
    input  wire tcm_pkg::tcm_id_t   m1_aw_id,
    input  wire tcm_pkg::tcm_data_t m1_w_data,
    input  wire tcm_pkg::tcm_strb_t m1_w_strb,
    output logic                    m1_b_valid,
    input  wire                     m1_b_ready,
    output tcm_pkg::tcm_id_t        m1_b_id
);

    tcm_bus_if itcm_bus ();
    tcm_bus_if dtcm_bus ();

    // master ports share names with the top, so they connect implicitly
    tcm_router i_tcm_router (
        .*,
        .itcm(itcm_bus),
        .dtcm(dtcm_bus)
    );

    tcm_bank #(
        .DEPTH_WORDS(`ITCM_SIZE / (`TCM_DATA_W / 8))
    ) itcm_bank (
        .clk  (clk),
        .rst_n(rst_n),
        .bus  (itcm_bus)
    );

    tcm_bank #(
        .DEPTH_WORDS(`DTCM_SIZE / (`TCM_DATA_W / 8))
    ) dtcm_bank (
        .clk  (clk),
        .rst_n(rst_n),
        .bus  (dtcm_bus)
    );

endmodule

`default_nettype wire

// File: bench/tcm_subsys_sva.sv
/*
 Protocol checks for the TCM subsystem top level.
 Response hold until taken, m0 fetch decode, quiet responses out of reset.
 */

`timescale 1ns/1ps
`default_nettype none

`include "tcm_defs.svh"

module tcm_subsys_sva (
    input wire                     clk,
    input wire                     rst_n,
    input wire                     m0_ar_ready,
    input wire tcm_pkg::tcm_addr_t m0_ar_addr,
    input wire                     m0_r_valid,
    input wire                     m0_r_ready,
    input wire tcm_pkg::tcm_data_t m0_r_data,
    input wire tcm_pkg::tcm_id_t   m0_r_id,
    input wire                     m1_r_valid,
    input wire                     m1_r_ready,
    input wire tcm_pkg::tcm_data_t m1_r_data,
    input wire tcm_pkg::tcm_id_t   m1_r_id,
    input wire                     m1_b_valid,
    input wire                     m1_b_ready,
    input wire tcm_pkg::tcm_id_t   m1_b_id
);

    // failure tallies, summed for the testbench's closing report
    int m0_hold_fails = 0;
    int m1_hold_fails = 0;
    int b_hold_fails  = 0;
    int decode_fails  = 0;
    int reset_fails   = 0;
    int fail_count;

    always_comb fail_count = m0_hold_fails + m1_hold_fails + b_hold_fails
                             + decode_fails + reset_fails;

    m0_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m0_r_valid && !m0_r_ready |=> m0_r_valid && $stable(m0_r_data) && $stable(m0_r_id))
    else begin
        $error("m0 read response changed before it was taken");
        m0_hold_fails++;
    end

    m1_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m1_r_valid && !m1_r_ready |=> m1_r_valid && $stable(m1_r_data) && $stable(m1_r_id))
    else begin
        $error("m1 read response changed before it was taken");
        m1_hold_fails++;
    end

    m1_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m1_b_valid && !m1_b_ready |=> m1_b_valid && $stable(m1_b_id))
    else begin
        $error("m1 write response changed before it was taken");
        b_hold_fails++;
    end

    // fetch port only ever reaches the ITCM window
    m0_decode: assert property (@(posedge clk) disable iff (!rst_n)
        m0_ar_ready |-> (m0_ar_addr - `ITCM_BASE) < `ITCM_SIZE)
    else begin
        $error("m0 read address accepted outside the ITCM window");
        decode_fails++;
    end

    quiet_after_reset: assert property (@(posedge clk)
        !rst_n |=> !(m0_r_valid || m1_r_valid || m1_b_valid))
    else begin
        $error("response valid in the cycle after reset");
        reset_fails++;
    end

endmodule

bind tcm_subsys tcm_subsys_sva i_tcm_subsys_sva (
    .clk(clk), .rst_n(rst_n), .m0_ar_ready(m0_ar_ready), .m0_ar_addr(m0_ar_addr),
    .m0_r_valid(m0_r_valid), .m0_r_ready(m0_r_ready), .m0_r_data(m0_r_data),
    .m0_r_id(m0_r_id), .m1_r_valid(m1_r_valid), .m1_r_ready(m1_r_ready),
    .m1_r_data(m1_r_data), .m1_r_id(m1_r_id), .m1_b_valid(m1_b_valid),
    .m1_b_ready(m1_b_ready), .m1_b_id(m1_b_id)
);

`default_nettype wire

// File: bench/tcm_subsys_tb.sv
/*
 Testbench for the TCM subsystem.
 Directed tests of m1 load/store, m0 fetch, ITCM read arbitration,
 byte strobes, read back-pressure and fetches to unmapped windows.
 */

`timescale 1ns/1ps
`default_nettype none

`include "tcm_defs.svh"

module tcm_subsys_tb;

    localparam int TIMEOUT_CYCLES = 50;
    localparam int CH_M0_AR       = 0;
    localparam int CH_M1_AR       = 1;
    localparam int CH_M1_AW       = 2;
    localparam int CH_M0_R        = 3;
    localparam int CH_M1_R        = 4;
    localparam int CH_M1_B        = 5;
    localparam int CH_M1_R_VALID  = 6;

    logic               clk;
    logic               rst_n;
    logic               m0_ar_valid;
    logic               m0_ar_ready;
    tcm_pkg::tcm_addr_t m0_ar_addr;
    tcm_pkg::tcm_id_t   m0_ar_id;
    logic               m0_r_valid;
    logic               m0_r_ready;
    tcm_pkg::tcm_data_t m0_r_data;
    tcm_pkg::tcm_id_t   m0_r_id;
    logic               m1_ar_valid;
    logic               m1_ar_ready;
    tcm_pkg::tcm_addr_t m1_ar_addr;
    tcm_pkg::tcm_id_t   m1_ar_id;
    logic               m1_r_valid;
    logic               m1_r_ready;
    tcm_pkg::tcm_data_t m1_r_data;
    tcm_pkg::tcm_id_t   m1_r_id;
    logic               m1_aw_valid;
    logic               m1_aw_ready;
    tcm_pkg::tcm_addr_t m1_aw_addr;
    tcm_pkg::tcm_id_t   m1_aw_id;
    tcm_pkg::tcm_data_t m1_w_data;
    tcm_pkg::tcm_strb_t m1_w_strb;
    logic               m1_b_valid;
    logic               m1_b_ready;
    tcm_pkg::tcm_id_t   m1_b_id;

    int seed;
    int mismatches;
    int timeouts;
    // expected memory contents by word address
    tcm_pkg::tcm_data_t model [tcm_pkg::tcm_addr_t];

    // testbench signal names match the DUT ports
    tcm_subsys i_tcm_subsys (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        mismatches++;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t: no %s handshake within %0d cycles", $time, what,
                 TIMEOUT_CYCLES);
        timeouts++;
    endtask

    // bytes with their strobe set come from the new word
    function automatic tcm_pkg::tcm_data_t merge_word(input tcm_pkg::tcm_data_t old_word,
            input tcm_pkg::tcm_data_t new_word, input tcm_pkg::tcm_strb_t strb);
        tcm_pkg::tcm_data_t result;
        result = old_word;
        for (int i = 0; i < $bits(tcm_pkg::tcm_strb_t); i++) begin
            if (strb[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    function automatic logic handshake_seen(input int ch);
        case (ch)
            CH_M0_AR:      return m0_ar_valid && m0_ar_ready;
            CH_M1_AR:      return m1_ar_valid && m1_ar_ready;
            CH_M1_AW:      return m1_aw_valid && m1_aw_ready;
            CH_M0_R:       return m0_r_valid && m0_r_ready;
            CH_M1_R:       return m1_r_valid && m1_r_ready;
            CH_M1_B:       return m1_b_valid && m1_b_ready;
            CH_M1_R_VALID: return m1_r_valid;
            default:       return 1'b0;
        endcase
    endfunction

    // sampled on the falling edge ahead of the transfer edge
    task automatic wait_for(input int ch, input int max_cycles, output logic seen);
        int cycles;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < max_cycles) begin
            @(negedge clk);
            seen = handshake_seen(ch);
            cycles++;
        end
    endtask

    task automatic m1_write(input tcm_pkg::tcm_addr_t addr, input tcm_pkg::tcm_data_t data,
                            input tcm_pkg::tcm_strb_t strb, input tcm_pkg::tcm_id_t id);
        logic               seen;
        tcm_pkg::tcm_data_t old_word;
        @(posedge clk);
        m1_aw_valid <= 1'b1;
        m1_aw_addr  <= addr;
        m1_aw_id    <= id;
        m1_w_data   <= data;
        m1_w_strb   <= strb;
        wait_for(CH_M1_AW, TIMEOUT_CYCLES, seen);
        @(posedge clk);
        m1_aw_valid <= 1'b0;
        if (!seen) begin
            report_timeout("m1 write address");
        end else begin
            old_word = model.exists(addr) ? model[addr] : '0;
            model[addr] = merge_word(old_word, data, strb);
            wait_for(CH_M1_B, TIMEOUT_CYCLES, seen);
            if (!seen) begin
                report_timeout("m1 write response");
            end else begin
                assert (m1_b_id == id)
                    else report_mismatch($sformatf("write %h: b_id %0d, expected %0d",
                                                   addr, m1_b_id, id));
                @(posedge clk);
            end
        end
    endtask

    task automatic m1_read(input tcm_pkg::tcm_addr_t addr, input tcm_pkg::tcm_id_t id,
                           output tcm_pkg::tcm_data_t data);
        logic seen;
        data = '0;
        @(posedge clk);
        m1_ar_valid <= 1'b1;
        m1_ar_addr  <= addr;
        m1_ar_id    <= id;
        wait_for(CH_M1_AR, TIMEOUT_CYCLES, seen);
        @(posedge clk);
        m1_ar_valid <= 1'b0;
        if (!seen) begin
            report_timeout("m1 read address");
        end else begin
            wait_for(CH_M1_R, TIMEOUT_CYCLES, seen);
            if (!seen) begin
                report_timeout("m1 read data");
            end else begin
                data = m1_r_data;
                assert (m1_r_id == id)
                    else report_mismatch($sformatf("m1 read %h: r_id %0d, expected %0d",
                                                   addr, m1_r_id, id));
                @(posedge clk);
            end
        end
    endtask

    task automatic m0_read(input tcm_pkg::tcm_addr_t addr, input tcm_pkg::tcm_id_t id,
                           output tcm_pkg::tcm_data_t data);
        logic seen;
        data = '0;
        @(posedge clk);
        m0_ar_valid <= 1'b1;
        m0_ar_addr  <= addr;
        m0_ar_id    <= id;
        wait_for(CH_M0_AR, TIMEOUT_CYCLES, seen);
        @(posedge clk);
        m0_ar_valid <= 1'b0;
        if (!seen) begin
            report_timeout("m0 read address");
        end else begin
            wait_for(CH_M0_R, TIMEOUT_CYCLES, seen);
            if (!seen) begin
                report_timeout("m0 read data");
            end else begin
                data = m0_r_data;
                assert (m0_r_id == id)
                    else report_mismatch($sformatf("m0 read %h: r_id %0d, expected %0d",
                                                   addr, m0_r_id, id));
                // a fetch answer belongs to m0 alone
                assert (!m1_r_valid)
                    else report_mismatch("m1_r_valid high during an m0 fetch response");
                @(posedge clk);
            end
        end
    endtask

    task automatic test_dtcm_readback();
        tcm_pkg::tcm_addr_t addrs [$];
        tcm_pkg::tcm_addr_t addr;
        tcm_pkg::tcm_data_t data;
        logic [31:0]        rnd;
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            addr = `DTCM_BASE + {20'h0, rnd[9:0], 2'b00};
            data = $random(seed);
            m1_write(addr, data, 4'b1111, rnd[13:12]);
            addrs.push_back(addr);
        end
        foreach (addrs[i]) begin
            rnd = $random(seed);
            m1_read(addrs[i], rnd[1:0], data);
            assert (data == model[addrs[i]])
                else report_mismatch($sformatf("dtcm %h: read %h, expected %h",
                                               addrs[i], data, model[addrs[i]]));
        end
    endtask

    task automatic test_fetch_after_write();
        tcm_pkg::tcm_addr_t addr;
        tcm_pkg::tcm_data_t data;
        addr = `ITCM_BASE + 32'h20;
        data = $random(seed);
        // write and fetch responses each wait a few cycles for their taker
        @(posedge clk);
        m1_b_ready <= 1'b0;
        fork
            m1_write(addr, data, 4'b1111, 2'd2);
            begin
                repeat (4) @(posedge clk);
                m1_b_ready <= 1'b1;
            end
        join
        @(posedge clk);
        m0_r_ready <= 1'b0;
        fork
            m0_read(addr, 2'd1, data);
            begin
                repeat (4) @(posedge clk);
                m0_r_ready <= 1'b1;
            end
        join
        assert (data == model[addr])
            else report_mismatch($sformatf("fetch %h: read %h, expected %h",
                                           addr, data, model[addr]));
    endtask

    task automatic test_itcm_arbitration();
        tcm_pkg::tcm_addr_t addr0;
        tcm_pkg::tcm_addr_t addr1;
        tcm_pkg::tcm_data_t data0;
        tcm_pkg::tcm_data_t data1;
        addr0 = `ITCM_BASE + 32'h200;
        addr1 = `ITCM_BASE + 32'h204;
        data0 = $random(seed);
        m1_write(addr0, data0, 4'b1111, 2'd0);
        data1 = $random(seed);
        m1_write(addr1, data1, 4'b1111, 2'd0);
        fork
            m0_read(addr0, 2'd1, data0);
            m1_read(addr1, 2'd2, data1);
            begin
                repeat (4) begin
                    @(negedge clk);
                    if (m1_ar_valid) begin
                        assert (!m0_ar_ready)
                            else report_mismatch("m0_ar_ready high while m1 offers an ITCM read");
                    end
                end
            end
        join
        assert (data0 == model[addr0])
            else report_mismatch($sformatf("arbitrated m0 read %h, expected %h",
                                           data0, model[addr0]));
        assert (data1 == model[addr1])
            else report_mismatch($sformatf("arbitrated m1 read %h, expected %h",
                                           data1, model[addr1]));
    endtask

    task automatic test_strobe_merge();
        tcm_pkg::tcm_addr_t addr;
        tcm_pkg::tcm_data_t data;
        addr = `ITCM_BASE + 32'h100;
        data = $random(seed);
        m1_write(addr, data, 4'b1111, 2'd0);
        data = $random(seed);
        m1_write(addr, data, 4'b0101, 2'd1);
        data = $random(seed);
        m1_write(addr, data, 4'b1000, 2'd2);
        m1_read(addr, 2'd3, data);
        assert (data == model[addr])
            else report_mismatch($sformatf("strobe merge: read %h, expected %h",
                                           data, model[addr]));
    endtask

    task automatic test_read_backpressure();
        tcm_pkg::tcm_addr_t addr;
        tcm_pkg::tcm_data_t held_data;
        tcm_pkg::tcm_id_t   held_id;
        logic               seen;
        addr = `DTCM_BASE + 32'h80;
        held_data = $random(seed);
        m1_write(addr, held_data, 4'b1111, 2'd1);
        @(posedge clk);
        m1_r_ready  <= 1'b0;
        m1_ar_valid <= 1'b1;
        m1_ar_addr  <= addr;
        m1_ar_id    <= 2'd2;
        wait_for(CH_M1_AR, TIMEOUT_CYCLES, seen);
        @(posedge clk);
        m1_ar_valid <= 1'b0;
        if (!seen) begin
            report_timeout("m1 read address");
        end
        wait_for(CH_M1_R_VALID, TIMEOUT_CYCLES, seen);
        if (!seen) begin
            report_timeout("m1 read valid");
        end else begin
            held_data = m1_r_data;
            held_id   = m1_r_id;
            assert (held_data == model[addr] && held_id == 2'd2)
                else report_mismatch($sformatf("held read %h id %0d, expected %h id 2",
                                               held_data, held_id, model[addr]));
            repeat (5) begin
                @(negedge clk);
                assert (m1_r_valid && m1_r_data == held_data && m1_r_id == held_id)
                    else report_mismatch("m1 read response changed under back-pressure");
            end
        end
        @(posedge clk);
        m1_r_ready <= 1'b1;
        wait_for(CH_M1_R, TIMEOUT_CYCLES, seen);
        if (!seen) begin
            report_timeout("m1 read data after back-pressure");
        end else begin
            @(posedge clk);
        end
    endtask

    task automatic test_unmapped_fetch();
        logic seen;
        @(posedge clk);
        m0_ar_valid <= 1'b1;
        m0_ar_addr  <= `DTCM_BASE + 32'h40;
        m0_ar_id    <= 2'd3;
        wait_for(CH_M0_AR, 20, seen);
        assert (!seen)
            else report_mismatch("m0 read of a DTCM address was accepted");
        // withdraw the request
        @(posedge clk);
        m0_ar_valid <= 1'b0;
    endtask

    initial begin
        int sva_fails;
        seed        = 52462;
        mismatches  = 0;
        timeouts    = 0;
        rst_n       = 1'b0;
        m0_ar_valid = 1'b0;
        m0_ar_addr  = '0;
        m0_ar_id    = '0;
        m0_r_ready  = 1'b1;
        m1_ar_valid = 1'b0;
        m1_ar_addr  = '0;
        m1_ar_id    = '0;
        m1_r_ready  = 1'b1;
        m1_aw_valid = 1'b0;
        m1_aw_addr  = '0;
        m1_aw_id    = '0;
        m1_w_data   = '0;
        m1_w_strb   = '0;
        m1_b_ready  = 1'b1;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        test_dtcm_readback();
        test_fetch_after_write();
        test_itcm_arbitration();
        test_strobe_merge();
        test_read_backpressure();
        test_unmapped_fetch();

        repeat (5) @(posedge clk);
        sva_fails = i_tcm_subsys.i_tcm_subsys_sva.fail_count;
        $display("summary: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatches, timeouts, sva_fails);
        if (mismatches == 0 && timeouts == 0 && sva_fails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+logic
logic/tcm_pkg.sv
logic/tcm_bus_if.sv
logic/tcm_outstanding_cnt.sv
logic/tcm_bank.sv
logic/tcm_router.sv
logic/tcm_subsys.sv
bench/tcm_subsys_sva.sv
bench/tcm_subsys_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tcm_subsys_tb
FILELIST := vlog.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST)) logic/tcm_defs.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) +verilator+error+limit+100 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
